/* tb.f */
map_blit_pkg.sv
blit_ctrl_if.sv
apb_blit_regs.sv
blit_fsm.sv
pixel_counter.sv
pixel_path.sv
map_blit_top.sv
tb_blit_mem.sv
tb_map_blit.sv

/* tb_map_blit.sv */
`timescale 1ns/100ps

module tb_map_blit;

	localparam int          NUM_RUNS   = 20;
	localparam int          BUSY_COUNT = 40;
	localparam logic [31:0] ADDR_MASK  = 32'h0007_FFFF;

	logic                    clk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	map_blit_pkg::apb_addr_t paddr;
	map_blit_pkg::apb_data_t pwdata;
	map_blit_pkg::apb_data_t prdata;
	logic                    pready;
	logic                    pslverr;
	logic                    irq;
	logic                    map_re;
	map_blit_pkg::pix_addr_t map_addr;
	map_blit_pkg::pixel_t    map_rdata;
	logic                    map_rdy;
	logic                    frame_we;
	map_blit_pkg::pix_addr_t frame_addr;
	map_blit_pkg::pixel_t    frame_data;
	logic                    frame_rdy;
	logic                    always_rdy;

	int                      run_count [NUM_RUNS];
	int                      cycles;
	int                      cycle_limit;
	logic                    map_pend;
	logic                    frame_pend;
	map_blit_pkg::pix_addr_t prev_map_addr;
	map_blit_pkg::pix_addr_t prev_frame_addr;
	map_blit_pkg::pixel_t    prev_frame_data;

	map_blit_top map_blit_top_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.psel       (psel),
		.penable    (penable),
		.pwrite     (pwrite),
		.paddr      (paddr),
		.pwdata     (pwdata),
		.prdata     (prdata),
		.pready     (pready),
		.pslverr    (pslverr),
		.irq        (irq),
		.map_re     (map_re),
		.map_addr   (map_addr),
		.map_rdata  (map_rdata),
		.map_rdy    (map_rdy),
		.frame_we   (frame_we),
		.frame_addr (frame_addr),
		.frame_data (frame_data),
		.frame_rdy  (frame_rdy)
	);

	tb_blit_mem mem_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.always_rdy (always_rdy),
		.map_re     (map_re),
		.map_addr   (map_addr),
		.map_rdata  (map_rdata),
		.map_rdy    (map_rdy),
		.frame_we   (frame_we),
		.frame_addr (frame_addr),
		.frame_data (frame_data),
		.frame_rdy  (frame_rdy)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("Mismatch %s: expected %h, actual %h",
				name, expected, actual));
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			report_failure($sformatf("Timeout: the run did not end within %0d cycles",
				cycle_limit));
	end

	// Requests and their address and data must hold until ready.
	always @(posedge clk) begin
		if (!rst_n) begin
			map_pend   = 1'b0;
			frame_pend = 1'b0;
		end else begin
			check_value("map_re_and_frame_we", 32'd0, 32'(map_re && frame_we));
			if (map_pend) begin
				check_value("map_re", 32'd1, map_re);
				check_value("map_addr", prev_map_addr, map_addr);
			end
			if (frame_pend) begin
				check_value("frame_we", 32'd1, frame_we);
				check_value("frame_addr", prev_frame_addr, frame_addr);
				check_value("frame_data", prev_frame_data, frame_data);
			end
			map_pend        = map_re && !map_rdy;
			frame_pend      = frame_we && !frame_rdy;
			prev_map_addr   = map_addr;
			prev_frame_addr = frame_addr;
			prev_frame_data = frame_data;
		end
	end

	task automatic apb_access(input map_blit_pkg::apb_addr_t addr, input logic write,
		input map_blit_pkg::apb_data_t wdata, output map_blit_pkg::apb_data_t rdata,
		output logic err);
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		check_value("pready", 32'd1, pready);   // Zero wait states.
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input map_blit_pkg::apb_addr_t addr,
		input map_blit_pkg::apb_data_t data);
		map_blit_pkg::apb_data_t rdata;
		logic                    err;
		apb_access(addr, 1'b1, data, rdata, err);
	endtask

	task automatic read_check(input string name, input map_blit_pkg::apb_addr_t addr,
		input map_blit_pkg::apb_data_t expected);
		map_blit_pkg::apb_data_t rdata;
		logic                    err;
		apb_access(addr, 1'b0, '0, rdata, err);
		check_value(name, expected, rdata);
		check_value("pslverr", 32'd0, err);
	endtask

	task automatic start_run(input map_blit_pkg::pix_addr_t src,
		input map_blit_pkg::pix_addr_t dst, input int count);
		apb_write(map_blit_pkg::REG_SRC_BASE, 32'(src));
		apb_write(map_blit_pkg::REG_DST_BASE, 32'(dst));
		apb_write(map_blit_pkg::REG_PIX_COUNT, 32'(count));
		apb_write(map_blit_pkg::REG_CTRL, 32'h1);
	endtask

	// Done set and busy clear once irq is seen.
	task automatic wait_done();
		do
			@(posedge clk);
		while (!irq);
		read_check("status", map_blit_pkg::REG_STATUS, 32'h2);
	endtask

	task automatic clear_done();
		apb_write(map_blit_pkg::REG_STATUS, 32'h2);
		read_check("status", map_blit_pkg::REG_STATUS, 32'h0);
		check_value("irq", 32'd0, irq);
	endtask

	// Model: write k of a run lands at dst+k and holds map word src+k.
	task automatic check_frame(input map_blit_pkg::pix_addr_t src,
		input map_blit_pkg::pix_addr_t dst, input int count);
		logic [31:0]             exp_data [64];
		bit                      seen [64];
		map_blit_pkg::pix_addr_t offset;
		for (int i = 0; i < count; i++) begin
			exp_data[i] = mem_i.map_img[map_blit_pkg::pix_addr_t'(src + i)];
			seen[i]     = 1'b0;
		end
		check_value("write_count", count, mem_i.wr_addr.size());
		check_value("read_count", count, mem_i.read_count);
		for (int k = 0; k < mem_i.wr_addr.size(); k++) begin
			offset = mem_i.wr_addr[k] - dst;
			if (offset >= count)
				report_failure($sformatf("Frame address %h outside the run was written",
					mem_i.wr_addr[k]));
			if (seen[offset])
				report_failure($sformatf("Frame address %h was written twice",
					mem_i.wr_addr[k]));
			seen[offset] = 1'b1;
			check_value("frame_data", exp_data[offset], mem_i.wr_data[k]);
		end
	endtask

	task automatic do_run(input map_blit_pkg::pix_addr_t src,
		input map_blit_pkg::pix_addr_t dst, input int count, input logic force_rdy);
		@(negedge clk);
		always_rdy = force_rdy;
		mem_i.clear_shadow();
		start_run(src, dst, count);
		wait_done();
		check_frame(src, dst, count);
		clear_done();
	endtask

	initial begin
		int                      seed_val;
		map_blit_pkg::apb_data_t data;
		logic                    err;
		map_blit_pkg::pix_addr_t src;
		map_blit_pkg::pix_addr_t dst;
		seed_val   = $urandom(32'ha8cfa398);
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		always_rdy = 1'b0;
		cycles     = 0;
		cycle_limit = 200 + (BUSY_COUNT * 20 + 200) + 200;
		for (int r = 0; r < NUM_RUNS; r++) begin
			run_count[r] = 1 + ($urandom % 64);
			cycle_limit += run_count[r] * 20 + 200;
		end
		mem_i.fill_map();
		repeat (8) @(negedge clk);
		rst_n = 1'b1;

		check_value("irq", 32'd0, irq);
		check_value("map_re", 32'd0, map_re);
		check_value("frame_we", 32'd0, frame_we);
		read_check("status", map_blit_pkg::REG_STATUS, 32'h0);
		data = $urandom;
		apb_write(map_blit_pkg::REG_SRC_BASE, data);
		read_check("src_base", map_blit_pkg::REG_SRC_BASE, data & ADDR_MASK);
		data = $urandom;
		apb_write(map_blit_pkg::REG_DST_BASE, data);
		read_check("dst_base", map_blit_pkg::REG_DST_BASE, data & ADDR_MASK);
		data = $urandom;
		apb_write(map_blit_pkg::REG_PIX_COUNT, data);
		read_check("pix_count", map_blit_pkg::REG_PIX_COUNT, data & ADDR_MASK);
		read_check("ctrl", map_blit_pkg::REG_CTRL, 32'h0);
		apb_access(8'h14, 1'b0, '0, data, err);
		check_value("pslverr", 32'd1, err);
		apb_access(8'hFC, 1'b1, 32'h1, data, err);
		check_value("pslverr", 32'd1, err);

		for (int r = 0; r < NUM_RUNS; r++) begin
			src = map_blit_pkg::pix_addr_t'($urandom);
			dst = map_blit_pkg::pix_addr_t'($urandom);
			if (r % 4 == 1)
				src = map_blit_pkg::pix_addr_t'(ADDR_MASK - ($urandom % 48));   // Wraps.
			if (r % 3 == 2)
				dst = map_blit_pkg::pix_addr_t'(ADDR_MASK - ($urandom % 48));
			do_run(src, dst, run_count[r], r % 5 == 4);
		end

		// Second start in the middle of a run.
		@(negedge clk);
		always_rdy = 1'b0;
		mem_i.clear_shadow();
		src = map_blit_pkg::pix_addr_t'($urandom);
		dst = map_blit_pkg::pix_addr_t'($urandom);
		start_run(src, dst, BUSY_COUNT);
		do
			apb_access(map_blit_pkg::REG_STATUS, 1'b0, '0, data, err);
		while (!data[map_blit_pkg::STATUS_BUSY_BIT]);
		start_run(dst, src, 5);
		wait_done();
		repeat (20) @(negedge clk);
		check_value("map_re", 32'd0, map_re);
		check_frame(src, dst, BUSY_COUNT);
		clear_done();

		// Empty run, with ready forced so any request would complete.
		do_run(src, dst, 0, 1'b1);

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

/* tb_blit_mem.sv */
`timescale 1ns/100ps

module tb_blit_mem (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    always_rdy,
	input  logic                    map_re,
	input  map_blit_pkg::pix_addr_t map_addr,
	output map_blit_pkg::pixel_t    map_rdata,
	output logic                    map_rdy,
	input  logic                    frame_we,
	input  map_blit_pkg::pix_addr_t frame_addr,
	input  map_blit_pkg::pixel_t    frame_data,
	output logic                    frame_rdy
);

	localparam int DEPTH = 1 << map_blit_pkg::ADDR_W;

	bit [31:0]               map_img [DEPTH];
	map_blit_pkg::pix_addr_t wr_addr [$];   // Completed frame writes, in order.
	map_blit_pkg::pixel_t    wr_data [$];
	int                      read_count;

	initial begin
		map_rdata  = '0;
		map_rdy    = 1'b0;
		frame_rdy  = 1'b0;
		read_count = 0;
	end

	task automatic fill_map();
		for (int a = 0; a < DEPTH; a++)
			map_img[a] = $urandom;
	endtask

	task automatic clear_shadow();
		wr_addr.delete();
		wr_data.delete();
		read_count = 0;
	endtask

	// Ready is high about 60 percent of the time.
	always @(negedge clk) begin
		map_rdata <= map_img[map_addr];
		if (always_rdy) begin
			map_rdy   <= 1'b1;
			frame_rdy <= 1'b1;
		end else begin
			map_rdy   <= ($urandom % 10) < 6;
			frame_rdy <= ($urandom % 10) < 6;
		end
	end

	always @(posedge clk) begin
		if (rst_n && map_re && map_rdy)
			read_count++;
		if (rst_n && frame_we && frame_rdy) begin
			wr_addr.push_back(frame_addr);
			wr_data.push_back(frame_data);
		end
	end

endmodule

/* map_blit_top.sv */
`timescale 1ns/100ps

module map_blit_top (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  map_blit_pkg::apb_addr_t paddr,
	input  map_blit_pkg::apb_data_t pwdata,
	output map_blit_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    irq,
	output logic                    map_re,
	output map_blit_pkg::pix_addr_t map_addr,
	input  map_blit_pkg::pixel_t    map_rdata,
	input  logic                    map_rdy,
	output logic                    frame_we,
	output map_blit_pkg::pix_addr_t frame_addr,
	output map_blit_pkg::pixel_t    frame_data,
	input  logic                    frame_rdy
);

	logic load;
	logic capture;
	logic step;
	logic last;

	blit_ctrl_if ctrl_if ();

	apb_blit_regs apb_blit_regs_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.irq     (irq),
		.ctrl    (ctrl_if.regs)
	);

	blit_fsm blit_fsm_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl_if.engine),
		.map_rdy   (map_rdy),
		.frame_rdy (frame_rdy),
		.last      (last),
		.map_re    (map_re),
		.frame_we  (frame_we),
		.load      (load),
		.capture   (capture),
		.step      (step)
	);

	pixel_counter pixel_counter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (load),
		.step  (step),
		.count (ctrl_if.pix_count),
		.last  (last)
	);

	pixel_path pixel_path_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.load       (load),
		.capture    (capture),
		.step       (step),
		.src_base   (ctrl_if.src_base),
		.dst_base   (ctrl_if.dst_base),
		.rdata      (map_rdata),
		.map_addr   (map_addr),
		.frame_addr (frame_addr),
		.frame_data (frame_data)
	);

endmodule

/* pixel_path.sv */
`timescale 1ns/100ps

module pixel_path (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    load,
	input  logic                    capture,
	input  logic                    step,
	input  map_blit_pkg::pix_addr_t src_base,
	input  map_blit_pkg::pix_addr_t dst_base,
	input  map_blit_pkg::pixel_t    rdata,
	output map_blit_pkg::pix_addr_t map_addr,
	output map_blit_pkg::pix_addr_t frame_addr,
	output map_blit_pkg::pixel_t    frame_data
);

	map_blit_pkg::pix_addr_t src_addr;
	map_blit_pkg::pix_addr_t dst_addr;
	map_blit_pkg::pixel_t    pix_data;

	// Both counters wrap at 2^19.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_addr <= '0;
			dst_addr <= '0;
		end else if (load) begin
			src_addr <= src_base;
			dst_addr <= dst_base;
		end else if (step) begin
			src_addr <= src_addr + 1'b1;
			dst_addr <= dst_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (capture)
			pix_data <= rdata;   // Held until the write completes.
	end

	assign map_addr   = src_addr;
	assign frame_addr = dst_addr;
	assign frame_data = pix_data;

endmodule

/* pixel_counter.sv */
`timescale 1ns/100ps

module pixel_counter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load,
	input  logic                     step,
	input  map_blit_pkg::pix_count_t count,
	output logic                     last
);

	map_blit_pkg::pix_count_t remaining;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			remaining <= '0;
		else if (load)
			remaining <= count;
		else if (step)
			remaining <= remaining - 1'b1;
	end

	// One pixel left means this write ends the run.
	assign last = (remaining == map_blit_pkg::pix_count_t'(1));

	a_no_underflow: assert property (
		@(posedge clk) disable iff (!rst_n)
		step |-> (remaining != '0)
	) else $error("step with no pixels remaining");

endmodule

/* blit_fsm.sv */
`timescale 1ns/100ps

module blit_fsm (
	input  logic        clk,
	input  logic        rst_n,
	blit_ctrl_if.engine ctrl,
	input  logic        map_rdy,
	input  logic        frame_rdy,
	input  logic        last,
	output logic        map_re,
	output logic        frame_we,
	output logic        load,
	output logic        capture,
	output logic        step
);

	map_blit_pkg::blit_state_t state;
	map_blit_pkg::blit_state_t nxt_state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= map_blit_pkg::ST_IDLE;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		case (state)
			map_blit_pkg::ST_IDLE: begin
				if (ctrl.start) begin
					if (ctrl.pix_count == '0)
						nxt_state = map_blit_pkg::ST_FINISH;   // Empty run.
					else
						nxt_state = map_blit_pkg::ST_READ_PIXEL;
				end
			end
			map_blit_pkg::ST_READ_PIXEL: begin
				if (map_rdy)
					nxt_state = map_blit_pkg::ST_WRITE_PIXEL;
			end
			map_blit_pkg::ST_WRITE_PIXEL: begin
				if (frame_rdy) begin
					if (last)
						nxt_state = map_blit_pkg::ST_FINISH;
					else
						nxt_state = map_blit_pkg::ST_READ_PIXEL;
				end
			end
			map_blit_pkg::ST_FINISH: nxt_state = map_blit_pkg::ST_IDLE;
			default: nxt_state = map_blit_pkg::ST_IDLE;
		endcase
	end

	// Requests come straight from the state and hold under back-pressure.
	assign map_re   = (state == map_blit_pkg::ST_READ_PIXEL);
	assign frame_we = (state == map_blit_pkg::ST_WRITE_PIXEL);

	assign load    = (state == map_blit_pkg::ST_IDLE) && ctrl.start;
	assign capture = map_re && map_rdy;
	assign step    = frame_we && frame_rdy;

	assign ctrl.busy       = (state != map_blit_pkg::ST_IDLE);
	assign ctrl.done_pulse = (state == map_blit_pkg::ST_FINISH);

	a_one_request: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(map_re && frame_we)
	) else $error("map_re and frame_we high together");

	a_write_held: assert property (
		@(posedge clk) disable iff (!rst_n)
		frame_we && !frame_rdy |=> frame_we
	) else $error("frame_we dropped before frame_rdy");

endmodule

/* apb_blit_regs.sv */
`timescale 1ns/100ps

module apb_blit_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  map_blit_pkg::apb_addr_t paddr,
	input  map_blit_pkg::apb_data_t pwdata,
	output map_blit_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    irq,
	blit_ctrl_if.regs               ctrl
);

	logic                     access;
	logic                     wr_en;
	logic                     addr_hit;
	logic                     start_wr;
	logic                     done_clr;
	logic                     done;
	map_blit_pkg::pix_addr_t  src_base;
	map_blit_pkg::pix_addr_t  dst_base;
	map_blit_pkg::pix_count_t pix_count;

	assign access = psel && penable;
	assign wr_en  = access && pwrite;

	assign start_wr = wr_en && (paddr == map_blit_pkg::REG_CTRL) &&
		pwdata[map_blit_pkg::CTRL_START_BIT];
	assign done_clr = wr_en && (paddr == map_blit_pkg::REG_STATUS) &&
		pwdata[map_blit_pkg::STATUS_DONE_BIT];

	// Read mux and offset decode.
	always_comb begin
		addr_hit = 1'b1;
		prdata   = '0;
		case (paddr)
			map_blit_pkg::REG_CTRL: prdata = '0;   // Write-only.
			map_blit_pkg::REG_STATUS: begin
				prdata[map_blit_pkg::STATUS_BUSY_BIT] = ctrl.busy;
				prdata[map_blit_pkg::STATUS_DONE_BIT] = done;
			end
			map_blit_pkg::REG_SRC_BASE:  prdata = map_blit_pkg::apb_data_t'(src_base);
			map_blit_pkg::REG_DST_BASE:  prdata = map_blit_pkg::apb_data_t'(dst_base);
			map_blit_pkg::REG_PIX_COUNT: prdata = map_blit_pkg::apb_data_t'(pix_count);
			default: addr_hit = 1'b0;
		endcase
	end

	assign pready  = 1'b1;   // Zero wait states.
	assign pslverr = access && !addr_hit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			src_base  <= '0;
			dst_base  <= '0;
			pix_count <= '0;
		end else if (wr_en) begin
			case (paddr)
				map_blit_pkg::REG_SRC_BASE:
					src_base <= pwdata[map_blit_pkg::ADDR_W-1:0];
				map_blit_pkg::REG_DST_BASE:
					dst_base <= pwdata[map_blit_pkg::ADDR_W-1:0];
				map_blit_pkg::REG_PIX_COUNT:
					pix_count <= pwdata[map_blit_pkg::CNT_W-1:0];
				default: ;
			endcase
		end
	end

	// Start is dropped while a run is in progress.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ctrl.start <= 1'b0;
		else
			ctrl.start <= start_wr && !ctrl.busy;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			done <= 1'b0;
		else if (ctrl.done_pulse)
			done <= 1'b1;   // Set beats clear.
		else if (done_clr)
			done <= 1'b0;
	end

	assign irq = done;

	assign ctrl.src_base  = src_base;
	assign ctrl.dst_base  = dst_base;
	assign ctrl.pix_count = pix_count;

	// A start must never reach the engine once busy has risen.
	a_no_start_when_busy: assert property (
		@(posedge clk) disable iff (!rst_n)
		!(ctrl.start && ctrl.busy)
	) else $error("start pulse while engine busy");

endmodule

/* blit_ctrl_if.sv */
`timescale 1ns/100ps

interface blit_ctrl_if;

	logic                     start;       // One-cycle pulse.
	map_blit_pkg::pix_addr_t  src_base;
	map_blit_pkg::pix_addr_t  dst_base;
	map_blit_pkg::pix_count_t pix_count;
	logic                     busy;
	logic                     done_pulse;  // High in ST_FINISH.

	modport regs (
		output start, src_base, dst_base, pix_count,
		input  busy, done_pulse
	);

	modport engine (
		input  start, src_base, dst_base, pix_count,
		output busy, done_pulse
	);

endinterface

/* map_blit_pkg.sv */
package map_blit_pkg;

	localparam int ADDR_W     = 19;
	localparam int PIX_W      = 32;
	localparam int CNT_W      = 19;
	localparam int APB_ADDR_W = 8;
	localparam int APB_DATA_W = 32;

	typedef logic [ADDR_W-1:0]     pix_addr_t;   // Wraps modulo 2^19.
	typedef logic [PIX_W-1:0]      pixel_t;
	typedef logic [CNT_W-1:0]      pix_count_t;
	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// Register map.
	localparam apb_addr_t REG_CTRL      = 8'h00;
	localparam apb_addr_t REG_STATUS    = 8'h04;
	localparam apb_addr_t REG_SRC_BASE  = 8'h08;
	localparam apb_addr_t REG_DST_BASE  = 8'h0C;
	localparam apb_addr_t REG_PIX_COUNT = 8'h10;

	localparam int CTRL_START_BIT  = 0;
	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;   // Write 1 to clear.

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ_PIXEL,
		ST_WRITE_PIXEL,
		ST_FINISH
	} blit_state_t;

endpackage
